// ==== logic/router_pkg.sv ====
package router_pkg;

    localparam int ADDR_W    = 6;
    localparam int GROUP_W   = 4;
    localparam int NUM_PORTS = 5;
    localparam int PORT_W    = 3;

    typedef logic [ADDR_W-1:0]  dest_addr_t;  // group in the top bits, spine select below.
    typedef logic [GROUP_W-1:0] group_id_t;
    typedef logic [PORT_W-1:0]  port_idx_t;
    typedef logic [1:0]         direction_t;

    // port 0 faces the GPU, ports 1 to 4 face the spines
    localparam port_idx_t PORT_GPU    = 3'd0;
    localparam port_idx_t PORT_SPINE1 = 3'd1;

    localparam direction_t DIR_IDLE = 2'b00;
    localparam direction_t DIR_UP   = 2'b01;  // gpu to spine.
    localparam direction_t DIR_DOWN = 2'b10;  // into the gpu port.
    localparam direction_t DIR_TURN = 2'b11;  // spine to spine.

    typedef enum logic {
        XB_IDLE,
        XB_MOVE
    } xbar_state_t;

endpackage

// ==== logic/port_fifo.sv ====
`timescale 1ns/10ps

module port_fifo #(
    parameter int WIDTH = 22,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // wraps for any depth.
    endfunction

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];  // head of the queue.

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("port_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("port_fifo: pop while empty");

endmodule

// ==== logic/rr_arbiter.sv ====
`timescale 1ns/10ps

module rr_arbiter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [router_pkg::NUM_PORTS-1:0] req,
    input  logic                             advance,
    output router_pkg::port_idx_t            grant,
    output logic                             grant_valid
);

    import router_pkg::*;

    port_idx_t prio_ptr;  // first port to look at.

    // scan all ports starting at the pointer, wrapping past the last one
    always_comb begin : pick
        int idx;
        grant       = '0;
        grant_valid = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = int'(prio_ptr) + i;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;
            end
            if (!grant_valid && req[idx]) begin
                grant       = port_idx_t'(idx);
                grant_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_ptr <= '0;
        end else if (advance && grant_valid) begin
            if (grant == port_idx_t'(NUM_PORTS - 1)) begin
                prio_ptr <= '0;
            end else begin
                prio_ptr <= grant + 1'b1;  // winner drops to lowest priority.
            end
        end
    end

    a_grant_has_req: assert property (@(posedge clk) disable iff (reset)
        grant_valid |-> req[grant])
        else $error("rr_arbiter: grant %0d without request", grant);

endmodule

// ==== logic/bidirectional_fsm_crossbar.sv ====
`timescale 1ns/10ps

module bidirectional_fsm_crossbar #(
    parameter int                    DWIDTH   = 16,
    parameter router_pkg::group_id_t GROUP_ID = 4'b0001
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         arb_enable,
    input  logic [router_pkg::NUM_PORTS-1:0][DWIDTH-1:0] head_data,
    input  router_pkg::dest_addr_t [router_pkg::NUM_PORTS-1:0] head_addr,
    input  logic [router_pkg::NUM_PORTS-1:0]             head_valid,
    input  logic [router_pkg::NUM_PORTS-1:0]             out_full,
    output logic [router_pkg::NUM_PORTS-1:0]             pop,
    output logic [router_pkg::NUM_PORTS-1:0]             push,
    output logic [DWIDTH-1:0]                            push_data,
    output logic                                         busy,
    output router_pkg::port_idx_t                        current_grant,
    output router_pkg::direction_t                       direction
);

    import router_pkg::*;

    xbar_state_t          state;
    port_idx_t            src_q;
    port_idx_t            dst_q;
    port_idx_t            target [NUM_PORTS];
    logic [NUM_PORTS-1:0] req;
    logic [NUM_PORTS-1:0] arb_req;
    port_idx_t            grant;
    logic                 grant_valid;

    // route each head, and only request when the target can take it
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (head_addr[p][ADDR_W-1 -: GROUP_W] == GROUP_ID) begin
                target[p] = PORT_GPU;  // local group goes down.
            end else begin
                target[p] = PORT_SPINE1 + port_idx_t'(head_addr[p][ADDR_W-GROUP_W-1:0]);
            end
            req[p] = head_valid[p] && !out_full[target[p]];
        end
    end

    assign arb_req = (state == XB_IDLE && arb_enable) ? req : '0;

    rr_arbiter u_arbiter (
        .clk(clk),
        .reset(reset),
        .req(arb_req),
        .advance(grant_valid),  // only valid in idle, so this is the latch.
        .grant(grant),
        .grant_valid(grant_valid)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= XB_IDLE;
            src_q <= PORT_GPU;
            dst_q <= PORT_GPU;
        end else begin
            case (state)
                XB_IDLE: begin
                    if (grant_valid) begin
                        state <= XB_MOVE;
                        src_q <= grant;
                        dst_q <= target[grant];
                    end
                end
                XB_MOVE: begin
                    state <= XB_IDLE;
                end
                default: begin
                    state <= XB_IDLE;
                end
            endcase
        end
    end

    assign busy          = (state == XB_MOVE);
    assign current_grant = src_q;
    assign push_data     = head_data[src_q];

    always_comb begin
        pop  = '0;
        push = '0;
        if (busy) begin
            pop[src_q]  = 1'b1;
            push[dst_q] = 1'b1;
        end
    end

    always_comb begin
        if (!busy) begin
            direction = DIR_IDLE;
        end else if (dst_q == PORT_GPU) begin
            direction = DIR_DOWN;  // gpu loopback reports as down too.
        end else if (src_q == PORT_GPU) begin
            direction = DIR_UP;
        end else begin
            direction = DIR_TURN;
        end
    end

    a_one_move: assert property (@(posedge clk) disable iff (reset)
        $onehot0(push) && $onehot0(pop))
        else $error("crossbar: more than one push or pop");

    // a latched move still finds its packet at the head and room at the target
    a_move_safe: assert property (@(posedge clk) disable iff (reset)
        busy |-> head_valid[src_q] && !out_full[dst_q])
        else $error("crossbar: move from %0d to %0d not safe", src_q, dst_q);

endmodule

// ==== logic/enhanced_router.sv ====
`timescale 1ns/10ps

module enhanced_router #(
    parameter int                    DWIDTH     = 16,
    parameter int                    FIFO_DEPTH = 8,
    parameter router_pkg::group_id_t GROUP_ID   = 4'b0001
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   arb_enable,

    input  logic [DWIDTH-1:0]      gpu_in_data,
    input  logic                   gpu_in_valid,
    input  router_pkg::dest_addr_t gpu_dest_addr,
    input  logic                   gpu_out_ready,
    output logic [DWIDTH-1:0]      gpu_out_data,
    output logic                   gpu_out_valid,

    input  logic [DWIDTH-1:0]      spine11_in_data,
    input  logic                   spine11_in_valid,
    input  router_pkg::dest_addr_t spine11_dest_addr,
    input  logic                   spine11_out_ready,
    output logic [DWIDTH-1:0]      spine11_out_data,
    output logic                   spine11_out_valid,

    input  logic [DWIDTH-1:0]      spine21_in_data,
    input  logic                   spine21_in_valid,
    input  router_pkg::dest_addr_t spine21_dest_addr,
    input  logic                   spine21_out_ready,
    output logic [DWIDTH-1:0]      spine21_out_data,
    output logic                   spine21_out_valid,

    input  logic [DWIDTH-1:0]      spine31_in_data,
    input  logic                   spine31_in_valid,
    input  router_pkg::dest_addr_t spine31_dest_addr,
    input  logic                   spine31_out_ready,
    output logic [DWIDTH-1:0]      spine31_out_data,
    output logic                   spine31_out_valid,

    input  logic [DWIDTH-1:0]      spine41_in_data,
    input  logic                   spine41_in_valid,
    input  router_pkg::dest_addr_t spine41_dest_addr,
    input  logic                   spine41_out_ready,
    output logic [DWIDTH-1:0]      spine41_out_data,
    output logic                   spine41_out_valid,

    output logic [3:0]             spine_fifo_in_full,
    output logic [3:0]             spine_fifo_in_empty,
    output logic [3:0]             spine_fifo_out_full,
    output logic [3:0]             spine_fifo_out_empty,
    output logic                   gpu_fifo_in_full,
    output logic                   gpu_fifo_in_empty,
    output logic                   gpu_fifo_out_full,
    output logic                   gpu_fifo_out_empty,

    output logic                   crossbar_busy,
    output router_pkg::port_idx_t  current_grant,
    output router_pkg::direction_t routing_direction
);

    import router_pkg::*;

    // per port arrays, index 0 is the gpu and 1 to 4 the spines
    logic [NUM_PORTS-1:0][DWIDTH-1:0] in_data;
    dest_addr_t [NUM_PORTS-1:0]       in_addr;
    logic [NUM_PORTS-1:0]             in_valid;
    logic [NUM_PORTS-1:0]             in_full;
    logic [NUM_PORTS-1:0]             in_empty;
    logic [NUM_PORTS-1:0][DWIDTH-1:0] head_data;
    dest_addr_t [NUM_PORTS-1:0]       head_addr;
    logic [NUM_PORTS-1:0]             xb_pop;
    logic [NUM_PORTS-1:0]             xb_push;
    logic [DWIDTH-1:0]                xb_data;
    logic [NUM_PORTS-1:0][DWIDTH-1:0] out_data;
    logic [NUM_PORTS-1:0]             out_valid;
    logic [NUM_PORTS-1:0]             out_ready;
    logic [NUM_PORTS-1:0]             out_pop;
    logic [NUM_PORTS-1:0]             out_full;
    logic [NUM_PORTS-1:0]             out_empty;

    assign in_data = {spine41_in_data, spine31_in_data, spine21_in_data, spine11_in_data,
                      gpu_in_data};
    assign in_addr = {spine41_dest_addr, spine31_dest_addr, spine21_dest_addr,
                      spine11_dest_addr, gpu_dest_addr};
    assign in_valid = {spine41_in_valid, spine31_in_valid, spine21_in_valid, spine11_in_valid,
                       gpu_in_valid};
    assign out_ready = {spine41_out_ready, spine31_out_ready, spine21_out_ready,
                        spine11_out_ready, gpu_out_ready};

    assign out_valid = ~out_empty;
    assign out_pop   = out_valid & out_ready;  // beat taken this cycle.

    assign {spine41_out_data, spine31_out_data, spine21_out_data, spine11_out_data,
            gpu_out_data} = out_data;
    assign {spine41_out_valid, spine31_out_valid, spine21_out_valid, spine11_out_valid,
            gpu_out_valid} = out_valid;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic [DWIDTH+ADDR_W-1:0] in_head;

        port_fifo #(
            .WIDTH(DWIDTH + ADDR_W),  // address rides with the data.
            .DEPTH(FIFO_DEPTH)
        ) u_in_fifo (
            .clk(clk),
            .reset(reset),
            .push(in_valid[p]),
            .push_data({in_addr[p], in_data[p]}),
            .pop(xb_pop[p]),
            .pop_data(in_head),
            .full(in_full[p]),
            .empty(in_empty[p])
        );

        assign head_addr[p] = in_head[DWIDTH +: ADDR_W];
        assign head_data[p] = in_head[DWIDTH-1:0];

        port_fifo #(
            .WIDTH(DWIDTH),
            .DEPTH(FIFO_DEPTH)
        ) u_out_fifo (
            .clk(clk),
            .reset(reset),
            .push(xb_push[p]),
            .push_data(xb_data),
            .pop(out_pop[p]),
            .pop_data(out_data[p]),
            .full(out_full[p]),
            .empty(out_empty[p])
        );
    end

    bidirectional_fsm_crossbar #(
        .DWIDTH(DWIDTH),
        .GROUP_ID(GROUP_ID)
    ) u_crossbar (
        .clk(clk),
        .reset(reset),
        .arb_enable(arb_enable),
        .head_data(head_data),
        .head_addr(head_addr),
        .head_valid(~in_empty),
        .out_full(out_full),
        .pop(xb_pop),
        .push(xb_push),
        .push_data(xb_data),
        .busy(crossbar_busy),
        .current_grant(current_grant),
        .direction(routing_direction)
    );

    assign spine_fifo_in_full   = in_full[4:1];
    assign spine_fifo_in_empty  = in_empty[4:1];
    assign spine_fifo_out_full  = out_full[4:1];
    assign spine_fifo_out_empty = out_empty[4:1];
    assign gpu_fifo_in_full     = in_full[PORT_GPU];
    assign gpu_fifo_in_empty    = in_empty[PORT_GPU];
    assign gpu_fifo_out_full    = out_full[PORT_GPU];
    assign gpu_fifo_out_empty   = out_empty[PORT_GPU];

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;  // released off the edge like the other inputs.
    end

endmodule

// ==== testbench/router_checker.sv ====
`timescale 1ns/10ps

module router_checker #(
    parameter int                    DWIDTH   = 16,
    parameter router_pkg::group_id_t GROUP_ID = 4'b0001
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         arb_enable,
    input  logic                         fair_check,
    input  logic [4:0]                   in_valid,
    input  logic [4:0][DWIDTH-1:0]       in_data,
    input  router_pkg::dest_addr_t [4:0] in_addr,
    input  logic [4:0]                   out_valid,
    input  logic [4:0]                   out_ready,
    input  logic [4:0][DWIDTH-1:0]       out_data,
    input  logic                         busy,
    input  router_pkg::port_idx_t        grant,
    output logic [4:0]                   dst_idle,
    output int                           pending,
    output int                           error_count
);

    import router_pkg::*;

    logic [DWIDTH-1:0] expect_q [25][$];  // one queue per source and destination pair.
    int                pend_dst [5];
    logic              arb_seen;
    logic              have_last;
    port_idx_t         last_grant;
    string             out_name [5] = '{"gpu_out_data", "spine11_out_data", "spine21_out_data",
                                        "spine31_out_data", "spine41_out_data"};

    // group match goes down to the gpu, anything else up to the selected spine
    function automatic int route_of(input dest_addr_t addr);
        if (addr[5:2] == GROUP_ID) begin
            return 0;
        end
        return int'(addr[1:0]) + 1;
    endfunction

    always @(posedge clk) begin
        int                src;
        int                dst;
        port_idx_t         next_grant;
        logic [DWIDTH-1:0] exp_data;
        if (reset) begin
            pending     = 0;
            error_count = 0;
            have_last   = 1'b0;
            dst_idle    = '1;
            for (int d = 0; d < 5; d++) begin
                pend_dst[d] = 0;
            end
        end else begin
            for (int p = 0; p < 5; p++) begin
                if (in_valid[p]) begin
                    dst = route_of(in_addr[p]);
                    expect_q[p*5 + dst].push_back(in_data[p]);
                    pend_dst[dst]++;
                    pending++;
                end
            end
            for (int d = 0; d < 5; d++) begin
                if (out_valid[d] && out_ready[d]) begin
                    src = int'(out_data[d][DWIDTH-1 -: 3]);  // payload carries its source.
                    if (src > 4 || expect_q[src*5 + d].size() == 0) begin
                        $display("Error: %s got %h but no packet was expected there",
                                 out_name[d], out_data[d]);
                        error_count++;
                    end else begin
                        exp_data = expect_q[src*5 + d].pop_front();
                        pend_dst[d]--;
                        pending--;
                        if (exp_data !== out_data[d]) begin
                            $display("Error: %s expected %h got %h", out_name[d], exp_data,
                                     out_data[d]);
                            error_count++;
                        end
                    end
                end
                dst_idle[d] = (pend_dst[d] == 0);
            end
            if (busy && !arb_seen) begin
                $display("the crossbar moved a packet while arbitration was disabled");
                error_count++;
            end
            if (fair_check && busy) begin
                next_grant = (last_grant == 3'd4) ? 3'd0 : last_grant + 1'b1;
                if (have_last && grant !== next_grant) begin
                    $display("Error: current_grant expected %h got %h", next_grant, grant);
                    error_count++;
                end
                have_last  = 1'b1;
                last_grant = grant;
            end else if (!fair_check) begin
                have_last = 1'b0;
            end
        end
        arb_seen = arb_enable;  // a move needs the enable one cycle earlier.
    end

endmodule

// ==== testbench/tb_enhanced_router.sv ====
`timescale 1ns/10ps

module tb_enhanced_router;

    import router_pkg::*;

    localparam int DWIDTH       = 16;
    localparam int FIFO_DEPTH   = 8;
    localparam int NUM_ROWS     = 15;
    localparam int CHK_NONE     = 0;
    localparam int CHK_GPU_FULL = 1;
    localparam int CHK_IN_FULL  = 2;
    localparam int CHK_FAIR     = 3;

    typedef struct {
        int         src;
        dest_addr_t addr;
        int         count;
        logic [4:0] ready;
        logic       arb;
        int         chk;
    } row_t;

    row_t stim [NUM_ROWS] = '{
        '{0, 6'h04,  6, 5'h1f, 1'b1, CHK_NONE},      // gpu back to itself.
        '{0, 6'h08,  5, 5'h1f, 1'b1, CHK_NONE},      // up to spine 1.
        '{0, 6'h0f,  5, 5'h1f, 1'b1, CHK_NONE},      // up to spine 4.
        '{2, 6'h05,  5, 5'h1f, 1'b1, CHK_NONE},      // down to the gpu.
        '{3, 6'h2a,  5, 5'h1f, 1'b1, CHK_NONE},      // turnaround onto its own spine.
        '{1, 6'h13,  4, 5'h1f, 1'b1, CHK_NONE},
        '{4, 6'h04, 10, 5'h1e, 1'b1, CHK_GPU_FULL},  // gpu output stalled.
        '{0, 6'h09,  6, 5'h1e, 1'b1, CHK_NONE},      // spines keep flowing.
        '{0, 6'h00,  0, 5'h1f, 1'b1, CHK_NONE},      // release.
        '{1, 6'h04,  8, 5'h1f, 1'b0, CHK_IN_FULL},
        '{0, 6'h08,  8, 5'h1f, 1'b0, CHK_IN_FULL},
        '{2, 6'h09,  8, 5'h1f, 1'b0, CHK_IN_FULL},
        '{3, 6'h0a,  8, 5'h1f, 1'b0, CHK_IN_FULL},
        '{4, 6'h0b,  8, 5'h1f, 1'b0, CHK_IN_FULL},
        '{0, 6'h00,  0, 5'h1f, 1'b1, CHK_FAIR}       // all five inputs drain together.
    };

    logic                     clk;
    logic                     reset;
    logic                     arb_enable;
    logic                     fair_check;
    logic [4:0][DWIDTH-1:0]   in_data;
    logic [4:0]               in_valid;
    dest_addr_t [4:0]         in_addr;
    logic [4:0]               out_ready;
    logic [4:0][DWIDTH-1:0]   out_data;
    logic [4:0]               out_valid;
    logic [3:0]               spine_in_full, spine_in_empty, spine_out_full, spine_out_empty;
    logic                     gpu_in_full, gpu_in_empty, gpu_out_full, gpu_out_empty;
    logic                     crossbar_busy;
    port_idx_t                current_grant;
    direction_t               routing_direction;
    logic [4:0]               in_full;
    logic [4:0]               dst_idle;
    int                       pending;
    int                       chk_errors;
    int                       errors;
    logic [31:0]              rng;

    assign in_full = {spine_in_full, gpu_in_full};

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clock (.clk(clk), .reset(reset));

    enhanced_router #(.DWIDTH(DWIDTH), .FIFO_DEPTH(FIFO_DEPTH), .GROUP_ID(4'b0001)) DUT (
        .clk(clk), .reset(reset), .arb_enable(arb_enable),
        .gpu_in_data(in_data[0]), .gpu_in_valid(in_valid[0]), .gpu_dest_addr(in_addr[0]),
        .gpu_out_ready(out_ready[0]), .gpu_out_data(out_data[0]), .gpu_out_valid(out_valid[0]),
        .spine11_in_data(in_data[1]), .spine11_in_valid(in_valid[1]),
        .spine11_dest_addr(in_addr[1]), .spine11_out_ready(out_ready[1]),
        .spine11_out_data(out_data[1]), .spine11_out_valid(out_valid[1]),
        .spine21_in_data(in_data[2]), .spine21_in_valid(in_valid[2]),
        .spine21_dest_addr(in_addr[2]), .spine21_out_ready(out_ready[2]),
        .spine21_out_data(out_data[2]), .spine21_out_valid(out_valid[2]),
        .spine31_in_data(in_data[3]), .spine31_in_valid(in_valid[3]),
        .spine31_dest_addr(in_addr[3]), .spine31_out_ready(out_ready[3]),
        .spine31_out_data(out_data[3]), .spine31_out_valid(out_valid[3]),
        .spine41_in_data(in_data[4]), .spine41_in_valid(in_valid[4]),
        .spine41_dest_addr(in_addr[4]), .spine41_out_ready(out_ready[4]),
        .spine41_out_data(out_data[4]), .spine41_out_valid(out_valid[4]),
        .spine_fifo_in_full(spine_in_full), .spine_fifo_in_empty(spine_in_empty),
        .spine_fifo_out_full(spine_out_full), .spine_fifo_out_empty(spine_out_empty),
        .gpu_fifo_in_full(gpu_in_full), .gpu_fifo_in_empty(gpu_in_empty),
        .gpu_fifo_out_full(gpu_out_full), .gpu_fifo_out_empty(gpu_out_empty),
        .crossbar_busy(crossbar_busy), .current_grant(current_grant),
        .routing_direction(routing_direction)
    );

    router_checker #(.DWIDTH(DWIDTH), .GROUP_ID(4'b0001)) u_check (
        .clk(clk), .reset(reset), .arb_enable(arb_enable), .fair_check(fair_check),
        .in_valid(in_valid), .in_data(in_data), .in_addr(in_addr),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .busy(crossbar_busy), .grant(current_grant),
        .dst_idle(dst_idle), .pending(pending), .error_count(chk_errors)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] expv);
        if (got !== expv) begin
            $display("Error: %s expected %h got %h", name, expv, got);
            errors++;
        end
    endtask

    // one beat per cycle, holding off while the source fifo is full
    task automatic send_packets(input int src, input dest_addr_t addr, input int count);
        int sent;
        sent = 0;
        while (sent < count) begin
            in_valid[src] = 1'b0;
            if (!in_full[src]) begin
                rng           = lcg_next(rng);
                in_data[src]  = {3'(src), rng[28:16]};  // source tag in the top bits.
                in_addr[src]  = addr;
                in_valid[src] = 1'b1;
                sent++;
            end
            next_cycle();
        end
        in_valid[src] = 1'b0;
    endtask

    task automatic settle(input logic [4:0] ready);
        int n;
        n = 0;
        while (((dst_idle | ~ready) != 5'h1f || crossbar_busy) && n < 400) begin
            next_cycle();
            n++;
        end
        if (n == 400) begin
            $display("traffic did not drain within 400 cycles");
            errors++;
        end
    endtask

    initial begin : watchdog
        int limit;
        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += stim[r].count * 10;
        end
        repeat (limit) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int n;
        in_data    = '0;
        in_valid   = '0;
        in_addr    = '0;
        out_ready  = '0;
        arb_enable = 1'b0;
        fair_check = 1'b0;
        errors     = 0;
        rng        = 32'hd3b1;
        wait (!reset);
        next_cycle();
        check_eq("gpu_fifo_in_empty", gpu_in_empty, 8'h1);
        check_eq("gpu_fifo_out_empty", gpu_out_empty, 8'h1);
        check_eq("spine_fifo_in_empty", spine_in_empty, 8'hf);
        check_eq("spine_fifo_out_empty", spine_out_empty, 8'hf);
        check_eq("gpu_fifo_in_full", gpu_in_full, 8'h0);
        check_eq("gpu_fifo_out_full", gpu_out_full, 8'h0);
        check_eq("spine_fifo_in_full", spine_in_full, 8'h0);
        check_eq("spine_fifo_out_full", spine_out_full, 8'h0);
        check_eq("out_valid", out_valid, 8'h0);
        check_eq("crossbar_busy", crossbar_busy, 8'h0);
        check_eq("current_grant", current_grant, 8'h0);
        check_eq("routing_direction", routing_direction, 8'h0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            out_ready  = stim[r].ready;
            arb_enable = stim[r].arb;
            fair_check = (stim[r].chk == CHK_FAIR);
            send_packets(stim[r].src, stim[r].addr, stim[r].count);
            if (stim[r].arb) begin
                settle(stim[r].ready);
            end else begin
                check_eq("crossbar_busy", crossbar_busy, 8'h0);
                check_eq("out_valid", out_valid, 8'h0);
            end
            if (stim[r].chk == CHK_GPU_FULL) begin
                n = 0;
                while (!gpu_out_full && n < 50) begin
                    next_cycle();
                    n++;
                end
                check_eq("gpu_fifo_out_full", gpu_out_full, 8'h1);
            end else if (stim[r].chk == CHK_IN_FULL) begin
                check_eq("fifo_in_full", in_full[stim[r].src], 8'h1);
            end
            fair_check = 1'b0;
        end
        if (pending != 0) begin
            $display("%0d packets were sent but never delivered", pending);
            errors++;
        end
        $display("errors: checker %0d, testbench %0d", chk_errors, errors);
        if (errors == 0 && chk_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
logic/router_pkg.sv
logic/port_fifo.sv
logic/rr_arbiter.sv
logic/bidirectional_fsm_crossbar.sv
logic/enhanced_router.sv
testbench/tb_clock_gen.sv
testbench/router_checker.sv
testbench/tb_enhanced_router.sv

// ==== Bender.yml ====
package:
  name: enhanced_router

sources:
  - files:
      - logic/router_pkg.sv
      - logic/port_fifo.sv
      - logic/rr_arbiter.sv
      - logic/bidirectional_fsm_crossbar.sv
      - logic/enhanced_router.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/router_checker.sv
      - testbench/tb_enhanced_router.sv
